// File: common/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

	localparam int SHADER_LANES = 4;
	localparam int WORD_BITS = 32;
	localparam int SHAMT_BITS = $clog2(WORD_BITS);

	// Number of register stages between in_valid and out_valid.
	localparam int FPINT_LATENCY = 3;

	typedef logic [WORD_BITS-1:0] word;

	typedef word [SHADER_LANES-1:0] lanes_t;

	typedef enum logic [1:0] {
		SHIFT_NONE  = 2'd0,
		SHIFT_RIGHT = 2'd1,
		SHIFT_CLZ   = 2'd2
	} shift_fn_t;

	// One operation word is shared by all lanes of an item.
	typedef struct packed {
		logic      minmax_abs;
		logic      minmax_swap;
		logic      minmax_zero_min;
		logic      addsub_sub;
		logic      shiftr_int_signed;
		shift_fn_t shift_fn;
	} fpint_op_t;

	typedef struct packed {
		word hi;
		word lo;
	} minmax_out_t;

	typedef struct packed {
		word                   sum;
		logic [SHAMT_BITS-1:0] shamt; // Low bits of lo, used by the shifter.
	} addsub_out_t;

endpackage

`default_nettype wire

// File: fpint/fpint_minmax.sv
`timescale 1ns/1ps
`default_nettype none

module fpint_minmax
(
	input  logic                 clk,

	input  gfx_pkg::word         a,
	                             b,
	input  logic                 abs_en,
	                             swap,
	                             zero_min,

	output gfx_pkg::minmax_out_t res
);

	import gfx_pkg::*;

	word  abs_a;
	word  abs_b;
	word  hi;
	word  lo;
	logic a_not_less;

	// Two's complement negation leaves the most negative value unchanged.
	function automatic word abs_word(input word v);
		word r;
		r = v;
		if (v[WORD_BITS-1]) begin
			r = ~v + 1'b1;
		end
		return r;
	endfunction

	always_comb begin
		abs_a = a;
		abs_b = b;
		if (abs_en) begin
			abs_a = abs_word(a);
			abs_b = abs_word(b);
		end

		a_not_less = $signed(abs_a) >= $signed(abs_b);

		if (swap && !a_not_less) begin
			hi = abs_b;
			lo = abs_a;
		end else begin
			hi = abs_a; // Without swap the operands keep their order.
			lo = abs_b;
		end
	end

	always_ff @(posedge clk) begin
		res.hi <= hi;
		res.lo <= zero_min ? '0 : lo;
	end

	// Ordering holds against the unzeroed smaller operand.
	a_swap_order: assert property (
		@(posedge clk) swap |=> $signed(res.hi) >= $signed($past(lo))
	) else $error("minmax: hi is below lo after swap");

endmodule

`default_nettype wire

// File: fpint/fpint_addsub.sv
`timescale 1ns/1ps
`default_nettype none

module fpint_addsub
(
	input  logic                 clk,

	input  gfx_pkg::minmax_out_t in,
	input  logic                 sub,

	output gfx_pkg::addsub_out_t res
);

	import gfx_pkg::*;

	word                   sum;
	logic [SHAMT_BITS-1:0] shamt;

	always_comb begin
		if (sub) begin
			sum = in.hi - in.lo;
		end else begin
			sum = in.hi + in.lo; // Carry out is dropped, so the sum wraps.
		end

		shamt = in.lo[SHAMT_BITS-1:0];
	end

	always_ff @(posedge clk) begin
		res.sum <= sum;
		res.shamt <= shamt;
	end

endmodule

`default_nettype wire

// File: fpint/fpint_shift.sv
`timescale 1ns/1ps
`default_nettype none

module fpint_shift
(
	input  logic                 clk,

	input  gfx_pkg::addsub_out_t in,
	input  gfx_pkg::shift_fn_t   fn,
	input  logic                 int_signed,

	output gfx_pkg::word         res
);

	import gfx_pkg::*;

	logic signed [WORD_BITS-1:0] sum_s;

	word shifted;
	word lz;

	// Zero gives the full word width.
	function automatic word count_lz(input word v);
		word  n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = WORD_BITS - 1; i >= 0; i--) begin
			if (v[i]) begin
				found = 1'b1;
			end else if (!found) begin
				n = n + 1'b1;
			end
		end
		return n;
	endfunction

	always_comb begin
		sum_s = in.sum;

		if (int_signed) begin
			shifted = sum_s >>> in.shamt; // Sign bit fills from the left.
		end else begin
			shifted = in.sum >> in.shamt;
		end

		lz = count_lz(in.sum);
	end

	always_ff @(posedge clk) begin
		case (fn)
			SHIFT_RIGHT: begin
				res <= shifted;
			end
			SHIFT_CLZ: begin
				res <= lz;
			end
			default: begin
				res <= in.sum;
			end
		endcase
	end

	a_clz_range: assert property (
		@(posedge clk) fn == SHIFT_CLZ |=> res <= WORD_BITS
	) else $error("shift: leading zero count out of range");

endmodule

`default_nettype wire

// File: fpint/gfx_shader_fpint.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_shader_fpint
(
	input  logic               clk,
	                           rst,

	input  logic               in_valid,
	input  gfx_pkg::fpint_op_t op,
	input  gfx_pkg::lanes_t    a,
	                           b,

	output logic               out_valid,
	output gfx_pkg::lanes_t    q
);

	import gfx_pkg::*;

	// Operation fields still needed once stage 1 has run.
	typedef struct packed {
		logic      sub;
		logic      int_signed;
		shift_fn_t fn;
	} s1_op_t;

	// Operation fields still needed once stage 2 has run.
	typedef struct packed {
		logic      int_signed;
		shift_fn_t fn;
	} s2_op_t;

	logic [FPINT_LATENCY-1:0] valid_q;

	s1_op_t op_s1;
	s2_op_t op_s2;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[FPINT_LATENCY-2:0], in_valid};
		end
	end

	always_ff @(posedge clk) begin
		op_s1.sub <= op.addsub_sub;
		op_s1.int_signed <= op.shiftr_int_signed;
		op_s1.fn <= op.shift_fn;

		op_s2.int_signed <= op_s1.int_signed;
		op_s2.fn <= op_s1.fn;
	end

	assign out_valid = valid_q[FPINT_LATENCY-1];

	for (genvar i = 0; i < SHADER_LANES; i++) begin : g_lane
		minmax_out_t mm;
		addsub_out_t as;

		fpint_minmax minmax
		(
			.clk,
			.a(a[i]),
			.b(b[i]),
			.abs_en(op.minmax_abs),
			.swap(op.minmax_swap),
			.zero_min(op.minmax_zero_min),
			.res(mm)
		);

		fpint_addsub addsub
		(
			.clk,
			.in(mm),
			.sub(op_s1.sub),
			.res(as)
		);

		fpint_shift shift
		(
			.clk,
			.in(as),
			.fn(op_s2.fn),
			.int_signed(op_s2.int_signed),
			.res(q[i])
		);
	end

	a_reset_quiet: assert property (
		@(posedge clk) rst |=> !out_valid
	) else $error("fpint: out_valid high right after reset");

	// Only checked once the whole pipe has filled past reset.
	a_valid_latency: assert property (
		@(posedge clk) (!rst) [*FPINT_LATENCY+1] |-> out_valid == $past(in_valid, FPINT_LATENCY)
	) else $error("fpint: out_valid does not follow in_valid");

endmodule

`default_nettype wire

// File: rtl/w3d_top.sv
`timescale 1ns/1ps
`default_nettype none

module w3d_top
(
	input  logic               clk,
	                           rst,

	input  logic               in_valid,
	input  gfx_pkg::lanes_t    a,
	                           b,

	input  logic               minmax_abs,
	                           minmax_swap,
	                           minmax_zero_min,
	                           addsub_sub,
	                           shiftr_int_signed,
	input  gfx_pkg::shift_fn_t shift_fn,

	output logic               out_valid,
	output gfx_pkg::lanes_t    q
);

	import gfx_pkg::*;

	fpint_op_t op;

	assign op.minmax_abs = minmax_abs;
	assign op.minmax_swap = minmax_swap;
	assign op.minmax_zero_min = minmax_zero_min;
	assign op.addsub_sub = addsub_sub;
	assign op.shiftr_int_signed = shiftr_int_signed;
	assign op.shift_fn = shift_fn;

	gfx_shader_fpint fpint
	(
		.clk,
		.rst,
		.in_valid,
		.op,
		.a,
		.b,
		.out_valid,
		.q
	);

endmodule

`default_nettype wire

// File: tb/tb_w3d.sv
`timescale 1ns/1ps
`default_nettype none

module tb_w3d;

	import gfx_pkg::*;

	localparam int MAX_VECTORS = 64;
	localparam int REC_WORDS = 1 + 3 * SHADER_LANES;
	localparam int RESET_CYCLES = 16;
	localparam int OP_BITS = $bits(fpint_op_t);

	typedef struct {
		int     idx;
		int     due;
		lanes_t q;
	} pending_t;

	logic      clk = 1'b0;
	logic      rst;
	logic      in_valid;
	lanes_t    a;
	lanes_t    b;
	logic      minmax_abs;
	logic      minmax_swap;
	logic      minmax_zero_min;
	logic      addsub_sub;
	logic      shiftr_int_signed;
	shift_fn_t shift_fn;
	logic      out_valid;
	lanes_t    q;

	word        vec_mem [0:REC_WORDS*MAX_VECTORS];
	int         num_vectors;
	int         cycle;
	int         limit;
	int         pulses;
	int         passed;
	int         failed;
	logic [7:0] lfsr_state;
	pending_t   pend [$];

	w3d_top dut0
	(
		.clk,
		.rst,
		.in_valid,
		.a,
		.b,
		.minmax_abs,
		.minmax_swap,
		.minmax_zero_min,
		.addsub_sub,
		.shiftr_int_signed,
		.shift_fn,
		.out_valid,
		.q
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// Taps 8, 6, 5 and 4 give a maximal length sequence.
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
		lfsr_state = {lfsr_state[6:0], fb};
		return fb;
	endfunction

	task automatic check_lanes(input lanes_t got, input lanes_t exp, input int idx);
		if (got !== exp) begin
			failed++;
			$display("Error q: vector %0d got %h expected %h", idx, got, exp);
		end else begin
			passed++;
			$display("vector %0d passed", idx);
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp) begin
			failed++;
			if (got === 1'b1 && pend.size() == 0) begin
				$display("out_valid asserted with no item pending");
			end else if (got === 1'b1) begin
				$display("out_valid asserted before vector %0d was due", pend[0].idx);
			end else if (got === 1'b0) begin
				$display("result missing for vector %0d", pend[0].idx);
			end else begin
				$display("out_valid is unknown at cycle %0d", cycle);
			end
		end
	endtask

	task automatic apply_vector(input int idx);
		int        base;
		fpint_op_t op;
		lanes_t    va;
		lanes_t    vb;
		pending_t  item;
		base = 1 + idx * REC_WORDS;
		op = fpint_op_t'(vec_mem[base][OP_BITS-1:0]);
		for (int i = 0; i < SHADER_LANES; i++) begin
			va[i] = vec_mem[base + 1 + i];
			vb[i] = vec_mem[base + 1 + SHADER_LANES + i];
			item.q[i] = vec_mem[base + 1 + 2 * SHADER_LANES + i];
		end
		item.idx = idx;
		item.due = cycle + FPINT_LATENCY + 1; // The counter still reads one behind here.
		in_valid <= 1'b1;
		a <= va;
		b <= vb;
		minmax_abs <= op.minmax_abs;
		minmax_swap <= op.minmax_swap;
		minmax_zero_min <= op.minmax_zero_min;
		addsub_sub <= op.addsub_sub;
		shiftr_int_signed <= op.shiftr_int_signed;
		shift_fn <= op.shift_fn;
		pend.push_back(item);
	endtask

	// Outputs are stable at the falling edge.
	always @(negedge clk) begin
		logic     due_now;
		pending_t head;
		due_now = 1'b0;
		if (pend.size() != 0) begin
			due_now = pend[0].due == cycle;
		end
		check_valid(out_valid, due_now);
		if (out_valid === 1'b1) begin
			pulses++;
		end
		if (due_now) begin
			head = pend.pop_front();
			if (out_valid === 1'b1) begin
				check_lanes(q, head.q, head.idx);
			end
		end
	end

	always @(posedge clk) begin
		if (cycle >= limit) begin
			failed++;
			$display("Timeout after %0d cycles with %0d results pending", cycle, pend.size());
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		minmax_abs = 1'b0;
		minmax_swap = 1'b0;
		minmax_zero_min = 1'b0;
		addsub_sub = 1'b0;
		shiftr_int_signed = 1'b0;
		shift_fn = SHIFT_NONE;
		cycle = 0;
		pulses = 0;
		passed = 0;
		failed = 0;
		lfsr_state = 8'd76;
		$readmemh("tb/fpint_vectors.txt", vec_mem);
		num_vectors = vec_mem[0];
		if (num_vectors < 1 || num_vectors > MAX_VECTORS) begin
			$display("Vector file gives an invalid count of %0d", num_vectors);
			failed++;
			num_vectors = 0;
		end
		limit = RESET_CYCLES + 2 * num_vectors + FPINT_LATENCY + 20;

		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int v = 0; v < num_vectors; v++) begin
			@(posedge clk);
			apply_vector(v);
			if (v < num_vectors - 1 && lfsr_bit()) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		while (pend.size() != 0) begin
			@(posedge clk);
		end
		repeat (FPINT_LATENCY + 2) @(posedge clk);

		if (pulses != num_vectors) begin
			failed++;
			$display("Saw %0d out_valid pulses for %0d vectors", pulses, num_vectors);
		end
		$display("Vectors passed: %0d, checks failed: %0d", passed, failed);
		if (failed == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/fpint_vectors.txt
// Columns: op a0 a1 a2 a3 b0 b1 b2 b3 q0 q1 q2 q3, first value is the vector count.
// Op bits: 6 abs, 5 swap, 4 zero_min, 3 sub, 2 signed, 1:0 fn (0 none, 1 right, 2 clz).
22
00 1 2 ffffffff 7fffffff 2 3 1 1 3 5 0 80000000
08 5 0 80000000 10 3 1 1 10 2 ffffffff 7fffffff 0
40 fffffffb 3 80000000 ffffffff 2 fffffffd 0 ffffffff 7 6 80000000 2
28 1 ffffffff 7fffffff 80000000 5 2 80000000 80000000 4 3 ffffffff 0
08 1 ffffffff 7fffffff 80000000 5 2 80000000 80000000 fffffffc fffffffd ffffffff 0
10 12345678 ffffffff 0 80000000 11111111 1 5 7 12345678 ffffffff 0 80000000
30 3 fffffff0 7fffffff 80000000 9 10 80000000 ffffffff 9 10 7fffffff ffffffff
68 fffffff6 4 80000000 0 3 fffffff8 1 0 7 4 80000001 0
70 ffffff9c 5 80000000 fffffffe 32 fffffff9 7fffffff 1 64 7 7fffffff 2
50 ffffffff 80000000 80000001 2a 1 2 3 4 1 80000000 7fffffff 2a
09 80000020 8000001f fffffff4 1e 20 1f 4 1f 80000000 1 fffffff 1
0d 80000020 8000001f fffffff4 1e 20 1f 4 1f 80000000 ffffffff ffffffff ffffffff
05 7fffffe0 100 bfffffc1 0 1f 8 3f 21 0 1 ffffffff 10
01 7fffffe0 100 bfffffc1 0 1f 8 3f 21 0 1 1 10
21 2 100 fffffffe 40 40 3 80 1 10 20 0 20
11 deadbeef 1 80000000 0 1f 1f 1f 1f deadbeef 1 80000000 0
02 0 ffffffff 1 80000000 0 0 0 0 20 0 1f 0
0a 10001 400 8000 20000000 1 0 0 0 f 15 10 2
02 ffffffff 7fffffff 2 0 1 0 0 1 20 1 1e 1f
0a 12345678 80000000 1 40000000 12345678 0 2 0 20 0 0 1
42 ffffffff 80000000 0 fffffff0 0 0 0 10 1f 0 20 1a
04 80000000 1 2 3 80000000 1 2 3 0 2 4 6
0c 0 1 2 3 1 1 1 1 ffffffff 0 1 2
6d ffffff00 10 80000000 3 2 fffffff0 8 1 3f 0 80000008 1
72 1 fffffffe 80000000 0 ffffff00 3 0 0 17 1e 20 20
00 89abcdef 13579bdf fedcba98 01234567 76543211 eca86420 2 10000000 0 ffffffff fedcba9a 11234567
08 0 80000000 12345678 ffffffff 80000000 7fffffff 87654321 ffffffff 80000000 1 8acf1357 0
01 ffffffff 12345678 0 80000000 0 0 4 1f ffffffff 12345678 0 1
05 ffffffff 12345678 0 80000000 0 0 4 1f ffffffff 12345678 0 ffffffff
0d 0 80000008 9 40000030 10 8 1 30 ffffffff ff800000 4 4000
09 0 80000008 9 40000030 10 8 1 30 ffff 800000 4 4000
0a 1 0 7fffffff 80000001 1 1 3fffffff 1 20 0 1 0
38 5 fffffffb 80000000 7ffffffe fffffffb 5 7fffffff 7fffffff 5 5 7fffffff 7fffffff
18 cafef00d 1 2 3 1 2 3 4 cafef00d 1 2 3

// File: tb.f
common/gfx_pkg.sv
fpint/fpint_minmax.sv
fpint/fpint_addsub.sv
fpint/fpint_shift.sv
fpint/gfx_shader_fpint.sv
rtl/w3d_top.sv
tb/tb_w3d.sv

// File: Makefile
# Verilator build for the fpint shader unit testbench.

TOP = tb_w3d

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f tb.f

# The run fails unless the pass line is present in the simulator output.
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
